//--- verilog/lsu_pkg.sv
package lsu_pkg;

    // Widths fixed by the ISA
    localparam int XLEN      = 64;
    localparam int ADDR_W    = 39;
    localparam int REG_IDX_W = 5;
    localparam int LANES     = 8;
    localparam int OFF_W     = 3;

    // Ready cycles from issue to writeback
    localparam int PIPE_DEPTH = 4;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [LANES-1:0]     byte_en_t;
    typedef logic [OFF_W-1:0]     byte_off_t;
    typedef logic [1:0]           op_kind_t;
    typedef logic [2:0]           size_t;
    typedef logic [1:0]           cache_ctl_t;

    localparam op_kind_t OP_ALU   = 2'd0;
    localparam op_kind_t OP_LOAD  = 2'd1;
    localparam op_kind_t OP_STORE = 2'd2;

    // funct3 order
    localparam size_t SZ_B  = 3'b000;
    localparam size_t SZ_H  = 3'b001;
    localparam size_t SZ_W  = 3'b010;
    localparam size_t SZ_D  = 3'b011;
    localparam size_t SZ_BU = 3'b100;
    localparam size_t SZ_HU = 3'b101;
    localparam size_t SZ_WU = 3'b110;

    localparam cache_ctl_t CTL_IDLE  = 2'b00;
    localparam cache_ctl_t CTL_READ  = 2'b01;
    localparam cache_ctl_t CTL_WRITE = 2'b10;

    ////////////////////
    // Access geometry
    ////////////////////

    function automatic logic [3:0] size_bytes(input size_t size);
        case (size)
            SZ_B, SZ_BU: size_bytes = 4'd1;
            SZ_H, SZ_HU: size_bytes = 4'd2;
            SZ_W, SZ_WU: size_bytes = 4'd4;
            default:     size_bytes = 4'd8;
        endcase
    endfunction

    // Field runs past byte 7 of the doubleword
    function automatic logic crosses_dword(input size_t size, input byte_off_t off);
        crosses_dword = ({1'b0, off} + size_bytes(size)) > 4'd8;
    endfunction

endpackage

//--- verilog/dcache_pkg.sv
package dcache_pkg;

    // Operation handed over by the execute stage
    typedef struct packed {
        logic              valid;
        lsu_pkg::op_kind_t kind;
        lsu_pkg::size_t    size;
        lsu_pkg::xlen_t    result;
        lsu_pkg::xlen_t    store_data;
        lsu_pkg::reg_idx_t rd;
    } ex_op_t;

    // Data cache request
    typedef struct packed {
        lsu_pkg::cache_ctl_t ctl;
        lsu_pkg::addr_t      addr;
        lsu_pkg::byte_en_t   byte_en;
        lsu_pkg::xlen_t      wdata;
    } dc_req_t;

    // Register writeback
    typedef struct packed {
        logic              valid;
        lsu_pkg::reg_idx_t rd;
        lsu_pkg::xlen_t    data;
    } wb_t;

    // Memory stage register
    typedef struct packed {
        logic              valid;
        lsu_pkg::op_kind_t kind;
        lsu_pkg::size_t    size;
        lsu_pkg::reg_idx_t rd;
        lsu_pkg::xlen_t    result;
    } stage_t;

endpackage

//--- verilog/store_align.sv
`timescale 1ns/100ps

module store_align
(
    input  dcache_pkg::ex_op_t  op,
    output dcache_pkg::dc_req_t req
);

    import lsu_pkg::*;

    byte_off_t off;
    byte_en_t  lane_mask;
    logic      is_load;
    logic      is_store;

    assign off      = op.result[OFF_W-1:0];
    assign is_load  = op.valid && (op.kind == OP_LOAD);
    assign is_store = op.valid && (op.kind == OP_STORE);

    ////////////////////
    // Lane pattern at offset zero
    ////////////////////

    always_comb
    begin
        case (size_bytes(op.size))
            4'd1:    lane_mask = 8'b0000_0001;
            4'd2:    lane_mask = 8'b0000_0011;
            4'd4:    lane_mask = 8'b0000_1111;
            default: lane_mask = 8'b1111_1111;
        endcase
    end

    ////////////////////
    // Request
    ////////////////////

    always_comb
    begin
        if (is_load)
        begin
            req.ctl = CTL_READ;
        end
        else if (is_store)
        begin
            req.ctl = CTL_WRITE;
        end
        else
        begin
            req.ctl = CTL_IDLE;
        end

        // 64-bit lines, so drop the byte offset
        req.addr = {op.result[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

        // Crossing store writes nothing
        if (is_store && !crosses_dword(op.size, off))
        begin
            req.byte_en = lane_mask << off;
        end
        else
        begin
            req.byte_en = '0;
        end

        req.wdata = op.store_data << {off, 3'b000};
    end

endmodule

//--- verilog/mem_pipe.sv
`timescale 1ns/100ps

module mem_pipe
(
    input  logic               CLK,
    input  logic               RST,
    input  dcache_pkg::ex_op_t op,
    input  logic               data_ready,
    input  logic               data_fault,
    output dcache_pkg::stage_t wb_stage
);

    import lsu_pkg::*;
    import dcache_pkg::*;

    // pipe[0..3] are ex_mem1, mem1_mem2, mem2_mem3 and mem3_wb
    stage_t pipe [PIPE_DEPTH];
    stage_t s1_next;

    ////////////////////
    // Stage 1 input
    ////////////////////

    always_comb
    begin
        // Stores write no register
        s1_next.valid  = op.valid && (op.kind != OP_STORE);
        s1_next.kind   = op.kind;
        s1_next.size   = op.size;
        s1_next.rd     = op.rd;
        s1_next.result = op.result;
    end

    ////////////////////
    // Stage registers
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            for (int i = 0; i < PIPE_DEPTH; i++)
            begin
                pipe[i].valid <= 1'b0;
            end
        end
        else if (data_ready)
        begin
            pipe[0] <= s1_next;

            // Fault belongs to the op now in stage 1
            pipe[1]       <= pipe[0];
            pipe[1].valid <= pipe[0].valid && !data_fault;

            for (int i = 2; i < PIPE_DEPTH; i++)
            begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign wb_stage = pipe[PIPE_DEPTH-1];

endmodule

//--- verilog/load_extract.sv
`timescale 1ns/100ps

module load_extract
(
    input  dcache_pkg::stage_t stage,
    input  lsu_pkg::xlen_t     rdata,
    output dcache_pkg::wb_t    wb
);

    import lsu_pkg::*;

    byte_off_t off;
    xlen_t     lane;
    xlen_t     load_data;

    assign off  = stage.result[OFF_W-1:0];

    // Addressed byte moved down to lane 0
    assign lane = rdata >> {off, 3'b000};

    ////////////////////
    // Extension
    ////////////////////

    always_comb
    begin
        if (crosses_dword(stage.size, off))
        begin
            load_data = '0;
        end
        else
        begin
            case (stage.size)
                SZ_B:    load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
                SZ_H:    load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
                SZ_W:    load_data = {{(XLEN-32){lane[31]}}, lane[31:0]};
                SZ_BU:   load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
                SZ_HU:   load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
                SZ_WU:   load_data = {{(XLEN-32){1'b0}}, lane[31:0]};
                // Aligned doubleword
                default: load_data = rdata;
            endcase
        end
    end

    ////////////////////
    // Writeback
    ////////////////////

    always_comb
    begin
        wb.valid = stage.valid;
        wb.rd    = stage.rd;

        if (stage.kind == OP_LOAD)
        begin
            wb.data = load_data;
        end
        else
        begin
            wb.data = stage.result;
        end
    end

endmodule

//--- verilog/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
(
    input  logic                CLK,
    input  logic                RST,
    input  dcache_pkg::ex_op_t  ex_op,
    input  logic                data_ready,
    input  logic                data_fault,
    input  lsu_pkg::xlen_t      rdata,
    output dcache_pkg::dc_req_t dc_req,
    output dcache_pkg::wb_t     wb
);

    import dcache_pkg::*;

    // Contents of mem3_wb
    stage_t wb_stage;

    ////////////////////
    // Request side
    ////////////////////

    store_align store_align_i
    (
        .op  (ex_op),
        .req (dc_req)
    );

    ////////////////////
    // Memory stages
    ////////////////////

    mem_pipe mem_pipe_i
    (
        .CLK        (CLK),
        .RST        (RST),
        .op         (ex_op),
        .data_ready (data_ready),
        .data_fault (data_fault),
        .wb_stage   (wb_stage)
    );

    ////////////////////
    // Writeback side
    ////////////////////

    load_extract load_extract_i
    (
        .stage (wb_stage),
        .rdata (rdata),
        .wb    (wb)
    );

endmodule

//--- tests/lsu_asserts.sv
`timescale 1ns/100ps

module lsu_asserts
(
    input logic                CLK,
    input logic                RST,
    input dcache_pkg::ex_op_t  ex_op,
    input dcache_pkg::dc_req_t dc_req,
    input dcache_pkg::wb_t     wb
);

    import lsu_pkg::*;

    // No request without a valid op
    idle_without_op: assert property (@(posedge CLK) disable iff (RST)
        !ex_op.valid |-> dc_req.ctl == CTL_IDLE)
    else
        $error("dc_req.ctl is not idle while ex_op.valid is low");

    // Enables only on writes
    enables_only_on_write: assert property (@(posedge CLK) disable iff (RST)
        dc_req.ctl != CTL_WRITE |-> dc_req.byte_en == '0)
    else
        $error("dc_req.byte_en is set on a request that is not a write");

    wb_clear_after_reset: assert property (@(posedge CLK)
        RST |=> !wb.valid)
    else
        $error("wb.valid is high in the cycle after reset");

endmodule

//--- tests/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;

    import lsu_pkg::*;
    import dcache_pkg::*;

    localparam xlen_t MEM_BASE = 64'h0000_0012_3456_7800;

    typedef struct packed {
        ex_op_t  op;
        logic    ready;
        logic    fault;
        dc_req_t exp_req;
        wb_t     exp_wb;
    } row_t;

    logic    CLK;
    logic    RST;
    ex_op_t  ex_op;
    logic    data_ready;
    logic    data_fault;
    xlen_t   rdata;
    dc_req_t dc_req;
    wb_t     wb;

    row_t     rows[$];
    xlen_t    ref_mem[8];
    logic     ref_valid[PIPE_DEPTH];
    reg_idx_t ref_rd[PIPE_DEPTH];
    xlen_t    ref_data[PIPE_DEPTH];

    xlen_t                 cache_mem[8];
    xlen_t                 load_q[$];
    logic [PIPE_DEPTH-2:0] load_in_stage;

    integer seed;
    int     error_count;
    int     rd_count;
    logic   rows_built;

    lsu_top dut_i
    (
        .CLK        (CLK),
        .RST        (RST),
        .ex_op      (ex_op),
        .data_ready (data_ready),
        .data_fault (data_fault),
        .rdata      (rdata),
        .dc_req     (dc_req),
        .wb         (wb)
    );

    bind lsu_top lsu_asserts lsu_asserts_i
    (
        .CLK    (CLK),
        .RST    (RST),
        .ex_op  (ex_op),
        .dc_req (dc_req),
        .wb     (wb)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    ////////////////////
    // Reference rules
    ////////////////////

    // Low two size bits give log2 of the access length
    function automatic int lane_count(input size_t size);
        return 1 << size[1:0];
    endfunction

    function automatic dc_req_t expected_req(input ex_op_t op);
        dc_req_t     req;
        byte_off_t   off;
        logic [15:0] mask;
        off  = op.result[2:0];
        mask = ((16'd1 << lane_count(op.size)) - 16'd1) << off;
        req  = '0;
        req.addr  = addr_t'(op.result) & ~addr_t'(7);
        req.wdata = op.store_data << (8 * off);
        if (op.valid && op.kind == OP_LOAD)
            req.ctl = CTL_READ;
        else if (op.valid && op.kind == OP_STORE)
            req.ctl = CTL_WRITE;
        else
            req.ctl = CTL_IDLE;
        if (req.ctl == CTL_WRITE && off + lane_count(op.size) <= 8)
            req.byte_en = mask[7:0];
        return req;
    endfunction

    function automatic xlen_t expected_load(input xlen_t word, input size_t size,
                                            input byte_off_t off);
        int    bits;
        xlen_t field;
        bits  = 8 * lane_count(size);
        field = word >> (8 * off);
        if (off + lane_count(size) > 8)
            return '0;
        if (size == SZ_D)
            return word;
        field = field & ((64'd1 << bits) - 64'd1);
        // funct3 bit 2 marks zero extension
        if (!size[2] && field[bits-1])
            field = field | ~((64'd1 << bits) - 64'd1);
        return field;
    endfunction

    function automatic ex_op_t make_op(input op_kind_t kind, input size_t size,
                                       input xlen_t result, input xlen_t store_data);
        ex_op_t op;
        op.valid      = 1'b1;
        op.kind       = kind;
        op.size       = size;
        op.result     = result;
        op.store_data = store_data;
        op.rd         = reg_idx_t'(rd_count);
        rd_count      = rd_count % 31 + 1;
        return op;
    endfunction

    function automatic xlen_t random_dword();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check_value(input xlen_t actual, input xlen_t expected, input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    // Appends one cycle and advances the reference pipeline
    task automatic add_row(input ex_op_t op, input logic ready, input logic fault);
        row_t r;
        r.op           = op;
        r.ready        = ready;
        r.fault        = fault;
        r.exp_req      = expected_req(op);
        r.exp_wb.valid = ref_valid[PIPE_DEPTH-1];
        r.exp_wb.rd    = ref_rd[PIPE_DEPTH-1];
        r.exp_wb.data  = ref_data[PIPE_DEPTH-1];
        rows.push_back(r);
        if (ready)
        begin
            for (int i = PIPE_DEPTH - 1; i > 0; i--)
            begin
                ref_valid[i] = ref_valid[i-1];
                ref_rd[i]    = ref_rd[i-1];
                ref_data[i]  = ref_data[i-1];
            end
            // Fault kills the op leaving stage 1
            ref_valid[1] = ref_valid[0] && !fault;
            ref_valid[0] = op.valid && op.kind != OP_STORE;
            ref_rd[0]    = op.rd;
            if (op.kind == OP_LOAD)
                ref_data[0] = expected_load(ref_mem[op.result[5:3]], op.size, op.result[2:0]);
            else
                ref_data[0] = op.result;
            for (int b = 0; b < 8; b++)
                if (r.exp_req.byte_en[b])
                    ref_mem[op.result[5:3]][8*b +: 8] = r.exp_req.wdata[8*b +: 8];
        end
    endtask

    task automatic build_table();
        ex_op_t held;
        seed     = 92;
        rd_count = 1;
        for (int i = 0; i < PIPE_DEPTH; i++)
            ref_valid[i] = 1'b0;
        // Whole doublewords first
        for (int w = 0; w < 8; w++)
            add_row(make_op(OP_STORE, SZ_D, MEM_BASE + 8 * w, random_dword()), 1'b1, 1'b0);
        // Word n is hit at offset n
        for (int s = 0; s < 4; s++)
            for (int off = 0; off < 8; off++)
                add_row(make_op(OP_STORE, size_t'(s), MEM_BASE + 9 * off, random_dword()),
                        1'b1, 1'b0);
        for (int s = 0; s < 7; s++)
            for (int off = 0; off < 8; off++)
                add_row(make_op(OP_LOAD, size_t'(s), MEM_BASE + 9 * off, '0), 1'b1, 1'b0);
        for (int i = 0; i < 6; i++)
            add_row(make_op(OP_ALU, SZ_D, random_dword(), '0), 1'b1, 1'b0);
        // Cache stall with the pipe full
        held = make_op(OP_LOAD, SZ_H, MEM_BASE + 26, '0);
        for (int i = 0; i < 3; i++)
            add_row(held, 1'b0, 1'b0);
        add_row(held, 1'b1, 1'b0);
        add_row(make_op(OP_ALU, SZ_D, random_dword(), '0), 1'b1, 1'b0);
        add_row(make_op(OP_ALU, SZ_D, random_dword(), '0), 1'b1, 1'b0);
        // Fault on the load one ready cycle after issue
        add_row(make_op(OP_LOAD, SZ_W, MEM_BASE + 44, '0), 1'b1, 1'b0);
        add_row(make_op(OP_ALU, SZ_D, random_dword(), '0), 1'b1, 1'b1);
        add_row(make_op(OP_ALU, SZ_D, random_dword(), '0), 1'b1, 1'b0);
        for (int i = 0; i < PIPE_DEPTH + 2; i++)
            add_row('0, 1'b1, 1'b0);
    endtask

    ////////////////////
    // Cache model
    ////////////////////

    always @(posedge CLK)
    begin
        if (RST)
            load_in_stage <= '0;
        else if (data_ready)
        begin
            // Load about to enter stage 4
            if (load_in_stage[PIPE_DEPTH-2])
                rdata <= load_q.pop_front();
            load_in_stage <= {load_in_stage[PIPE_DEPTH-3:0], dc_req.ctl == CTL_READ};
            if (dc_req.ctl == CTL_READ)
                load_q.push_back(cache_mem[dc_req.addr[5:3]]);
            if (dc_req.ctl == CTL_WRITE)
                for (int b = 0; b < 8; b++)
                    if (dc_req.byte_en[b])
                        cache_mem[dc_req.addr[5:3]][8*b +: 8] = dc_req.wdata[8*b +: 8];
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        string where;
        RST         = 1'b1;
        ex_op       = '0;
        data_ready  = 1'b0;
        data_fault  = 1'b0;
        rdata       = '0;
        error_count = 0;
        rows_built  = 1'b0;
        build_table();
        rows_built = 1'b1;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        foreach (rows[i])
        begin
            @(posedge CLK);
            ex_op      <= rows[i].op;
            data_ready <= rows[i].ready;
            data_fault <= rows[i].fault;
            @(negedge CLK);
            where = $sformatf("row %0d", i);
            check_value(64'(dc_req.ctl), 64'(rows[i].exp_req.ctl), {where, " ctl"});
            check_value(64'(dc_req.byte_en), 64'(rows[i].exp_req.byte_en), {where, " byte_en"});
            if (rows[i].exp_req.ctl != CTL_IDLE)
                check_value(64'(dc_req.addr), 64'(rows[i].exp_req.addr), {where, " addr"});
            if (rows[i].exp_req.ctl == CTL_WRITE)
                check_value(dc_req.wdata, rows[i].exp_req.wdata, {where, " wdata"});
            check_value(64'(wb.valid), 64'(rows[i].exp_wb.valid), {where, " wb.valid"});
            if (rows[i].exp_wb.valid)
            begin
                check_value(64'(wb.rd), 64'(rows[i].exp_wb.rd), {where, " wb.rd"});
                check_value(wb.data, rows[i].exp_wb.data, {where, " wb.data"});
            end
        end
        $display("Rows applied: %0d, errors: %0d", rows.size(), error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (rows_built);
        repeat (rows.size() * 20 + 100) @(posedge CLK);
        $display("Timeout: the stimulus table did not finish in %0d cycles",
                 rows.size() * 20 + 100);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src.f
verilog/lsu_pkg.sv
verilog/dcache_pkg.sv
verilog/store_align.sv
verilog/mem_pipe.sv
verilog/load_extract.sv
verilog/lsu_top.sv
tests/lsu_asserts.sv
tests/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the LSU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb \
    -f src.f \
    -o lsu_sim

./obj_dir/lsu_sim | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Run failed, see $LOG"
    exit 1
fi

echo "Run passed"
